// File: rtl/synth_pkg.sv
`default_nettype none

package synth_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    // Frequency register, two bytes
    localparam int FREQ_W = 16;
    // Phase accumulator
    localparam int ACC_W  = 24;
    // Byte registers, wave, envelope and level values
    localparam int REG_W  = 8;
    // Voice index field in the SPI frame
    localparam int VIDX_W = 2;

    // ======================================================================
    // Register map, frame bits 15..13
    // ======================================================================

    localparam logic [2:0] REG_FREQ_LO = 3'd0;
    localparam logic [2:0] REG_FREQ_HI = 3'd1;
    localparam logic [2:0] REG_PW      = 3'd2;
    // Attack in [3:0], decay in [7:4]
    localparam logic [2:0] REG_AD      = 3'd4;
    // Sustain level in [3:0], release in [7:4]
    localparam logic [2:0] REG_SR      = 3'd5;
    localparam logic [2:0] REG_WAVE    = 3'd6;

    // Waveform register bit positions
    localparam int WAVE_GATE  = 0;
    localparam int WAVE_TRI   = 4;
    localparam int WAVE_SAW   = 5;
    localparam int WAVE_PULSE = 6;

    // Envelope generator states
    typedef enum logic [2:0] {
        IDLE,
        ATTACK,
        DECAY,
        SUSTAIN,
        RELEASE
    } env_state_t;

endpackage

`default_nettype wire

// File: rtl/spi_voice_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_voice_regs #(
    parameter int NUM_VOICES = 4
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    // SPI pins, asynchronous to clk
    input  wire logic                         spi_clk,
    input  wire logic                         spi_cs_n,
    input  wire logic                         spi_mosi,
    // Per-voice register outputs
    output logic [synth_pkg::FREQ_W-1:0]      freq    [NUM_VOICES],
    output logic [synth_pkg::REG_W-1:0]       pw      [NUM_VOICES],
    output logic [synth_pkg::REG_W-1:0]       attack  [NUM_VOICES],
    output logic [synth_pkg::REG_W-1:0]       sustain [NUM_VOICES],
    output logic [synth_pkg::REG_W-1:0]       wave    [NUM_VOICES]
);

    import synth_pkg::*;

    // ======================================================================
    // Pin synchronizers
    // ======================================================================

    logic sclk_s1;
    logic sclk_s2;
    logic sclk_s3;
    logic cs_n_s1;
    logic cs_n_s2;
    logic mosi_s1;
    logic mosi_s2;

    // CS idles high, so its flops reset to 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_s1 <= 1'b0;
            sclk_s2 <= 1'b0;
            sclk_s3 <= 1'b0;
            cs_n_s1 <= 1'b1;
            cs_n_s2 <= 1'b1;
            mosi_s1 <= 1'b0;
            mosi_s2 <= 1'b0;
        end else begin
            sclk_s1 <= spi_clk;
            sclk_s2 <= sclk_s1;
            // Third stage only for edge detection
            sclk_s3 <= sclk_s2;
            cs_n_s1 <= spi_cs_n;
            cs_n_s2 <= cs_n_s1;
            mosi_s1 <= spi_mosi;
            mosi_s2 <= mosi_s1;
        end
    end

    logic sclk_rise;
    logic cs_active;

    assign sclk_rise = sclk_s2 && !sclk_s3;
    assign cs_active = !cs_n_s2;

    // ======================================================================
    // Frame shifter
    // ======================================================================

    // First 15 bits of the frame, the 16th comes straight from mosi_s2
    logic [14:0]       rx_shift;
    logic [3:0]        bit_cnt;
    logic [15:0]       frame;
    logic              frame_done;
    logic [2:0]        addr;
    logic [VIDX_W-1:0] vidx;
    logic [REG_W-1:0]  data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_shift <= '0;
            bit_cnt  <= '0;
        end else if (!cs_active) begin
            // Idle or aborted frame
            rx_shift <= '0;
            bit_cnt  <= '0;
        end else if (sclk_rise) begin
            rx_shift <= {rx_shift[13:0], mosi_s2};
            // Wraps to 0 after the 16th bit
            bit_cnt  <= bit_cnt + 4'd1;
        end
    end

    assign frame      = {rx_shift, mosi_s2};
    assign frame_done = cs_active && sclk_rise && (bit_cnt == 4'd15);

    // Bits 10..8 are don't-care
    assign addr = frame[15:13];
    assign vidx = frame[12:11];
    assign data = frame[REG_W-1:0];

    // ======================================================================
    // Register file
    // ======================================================================

    // An index with no matching voice writes nothing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                freq[v]    <= '0;
                pw[v]      <= '0;
                attack[v]  <= '0;
                sustain[v] <= '0;
                wave[v]    <= '0;
            end
        end else if (frame_done) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (vidx == VIDX_W'(v)) begin
                    case (addr)
                        REG_FREQ_LO: freq[v][REG_W-1:0]      <= data;
                        REG_FREQ_HI: freq[v][FREQ_W-1:REG_W] <= data;
                        REG_PW:      pw[v]                   <= data;
                        REG_AD:      attack[v]               <= data;
                        REG_SR:      sustain[v]              <= data;
                        REG_WAVE:    wave[v]                 <= data;
                        // Addresses 3 and 7 unused
                        default: ;
                    endcase
                end
            end
        end
    end

    // Partial frames never leave a stale count behind once CS drops
    a_cnt_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !cs_active |=> (bit_cnt == '0));

endmodule

`default_nettype wire

// File: rtl/sid_voice.sv
`timescale 1ns/1ps
`default_nettype none

module sid_voice (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         sample_tick,
    input  wire logic [synth_pkg::FREQ_W-1:0] freq,
    input  wire logic [synth_pkg::REG_W-1:0]  pw,
    input  wire logic [synth_pkg::REG_W-1:0]  attack,
    input  wire logic [synth_pkg::REG_W-1:0]  sustain,
    input  wire logic [synth_pkg::REG_W-1:0]  wave,
    output logic      [synth_pkg::REG_W-1:0]  level
);

    import synth_pkg::*;

    // ======================================================================
    // Phase accumulator and waveforms
    // ======================================================================

    logic [ACC_W-1:0] phase;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (sample_tick) begin
            // Wraps freely
            phase <= phase + ACC_W'(freq);
        end
    end

    logic [REG_W-1:0] p;
    logic [REG_W-1:0] saw_val;
    logic [REG_W-1:0] tri_val;
    logic [REG_W-1:0] pulse_val;
    logic [REG_W-1:0] wave_val;
    logic             any_sel;

    assign p         = phase[ACC_W-1 -: REG_W];
    assign saw_val   = p;
    // Fold the upper half back down
    assign tri_val   = {p[REG_W-2:0], 1'b0} ^ {REG_W{p[REG_W-1]}};
    assign pulse_val = (p < pw) ? '1 : '0;
    assign any_sel   = wave[WAVE_SAW] | wave[WAVE_TRI] | wave[WAVE_PULSE];

    // Selected waveforms are ANDed together
    always_comb begin
        wave_val = '1;
        if (wave[WAVE_SAW]) begin
            wave_val = wave_val & saw_val;
        end
        if (wave[WAVE_TRI]) begin
            wave_val = wave_val & tri_val;
        end
        if (wave[WAVE_PULSE]) begin
            wave_val = wave_val & pulse_val;
        end
        if (!any_sel) begin
            wave_val = '0;
        end
    end

    // ======================================================================
    // ADSR envelope
    // ======================================================================

    env_state_t       env_state;
    env_state_t       gated_state;
    env_state_t       nxt_state;
    logic [REG_W-1:0] env_val;
    logic [REG_W-1:0] nxt_env;
    logic             gate;
    logic [REG_W-1:0] atk_step;
    logic [REG_W-1:0] dec_step;
    logic [REG_W-1:0] rel_step;
    logic [REG_W-1:0] sus_level;
    logic [REG_W:0]   atk_sum;
    logic [REG_W:0]   dec_floor;

    assign gate      = wave[WAVE_GATE];
    // Step sizes are nibble + 1
    assign atk_step  = REG_W'(attack[3:0]) + REG_W'(1);
    assign dec_step  = REG_W'(attack[7:4]) + REG_W'(1);
    assign rel_step  = REG_W'(sustain[7:4]) + REG_W'(1);
    // Nibble times 17 spans 0..255
    assign sus_level = {sustain[3:0], sustain[3:0]};
    assign atk_sum   = (REG_W+1)'(env_val) + (REG_W+1)'(atk_step);
    assign dec_floor = (REG_W+1)'(sus_level) + (REG_W+1)'(dec_step);

    always_comb begin
        // Gate edges first
        gated_state = env_state;
        if (gate && (env_state == IDLE || env_state == RELEASE)) begin
            gated_state = ATTACK;
        end else if (!gate && (env_state == ATTACK || env_state == DECAY ||
                               env_state == SUSTAIN)) begin
            gated_state = RELEASE;
        end
        // Then the step of the new state
        nxt_state = gated_state;
        nxt_env   = env_val;
        case (gated_state)
            ATTACK: begin
                if (atk_sum >= (REG_W+1)'(2**REG_W - 1)) begin
                    nxt_env   = '1;
                    nxt_state = DECAY;
                end else begin
                    nxt_env = atk_sum[REG_W-1:0];
                end
            end
            DECAY: begin
                // Lands exactly on the sustain level
                if ((REG_W+1)'(env_val) <= dec_floor) begin
                    nxt_env   = sus_level;
                    nxt_state = SUSTAIN;
                end else begin
                    nxt_env = env_val - dec_step;
                end
            end
            RELEASE: begin
                if (env_val <= rel_step) begin
                    nxt_env   = '0;
                    nxt_state = IDLE;
                end else begin
                    nxt_env = env_val - rel_step;
                end
            end
            // SUSTAIN and IDLE hold
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            env_state <= IDLE;
            env_val   <= '0;
        end else if (sample_tick) begin
            env_state <= nxt_state;
            env_val   <= nxt_env;
        end
    end

    // ======================================================================
    // Output level, one cycle behind the tick
    // ======================================================================

    logic                 tick_d1;
    logic [2*REG_W-1:0]   product;

    assign product = wave_val * env_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_d1 <= 1'b0;
            level   <= '0;
        end else begin
            tick_d1 <= sample_tick;
            if (tick_d1) begin
                level <= product[2*REG_W-1:REG_W];
            end
        end
    end

    a_idle_silent: assert property (@(posedge clk) disable iff (!rst_n)
        (env_state == IDLE) |-> (env_val == '0));

    a_env_on_tick: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(env_val) |-> $past(sample_tick));

endmodule

`default_nettype wire

// File: rtl/voice_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module voice_mixer #(
    parameter int NUM_VOICES = 4,
    parameter int SAMPLE_DIV = 256,
    parameter int MIX_W      = 10
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [synth_pkg::REG_W-1:0] level [NUM_VOICES],
    output logic                             sample_tick,
    output logic      [MIX_W-1:0]            sample,
    output logic                             sample_valid
);

    localparam int CNT_W = $clog2(SAMPLE_DIV);

    // ======================================================================
    // Sample rate divider
    // ======================================================================

    logic [CNT_W-1:0] div_cnt;

    // First tick lands SAMPLE_DIV cycles out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
        end else if (div_cnt == CNT_W'(SAMPLE_DIV - 1)) begin
            div_cnt     <= '0;
            sample_tick <= 1'b1;
        end else begin
            div_cnt     <= div_cnt + CNT_W'(1);
            sample_tick <= 1'b0;
        end
    end

    // ======================================================================
    // Sum of voice levels
    // ======================================================================

    // Voices settle their level one cycle after the tick
    logic             tick_d1;
    logic             tick_d2;
    logic [MIX_W-1:0] level_sum;

    always_comb begin
        level_sum = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            level_sum = level_sum + MIX_W'(level[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_d1      <= 1'b0;
            tick_d2      <= 1'b0;
            sample_valid <= 1'b0;
            sample       <= '0;
        end else begin
            tick_d1      <= sample_tick;
            tick_d2      <= tick_d1;
            sample_valid <= tick_d2;
            if (tick_d2) begin
                sample <= level_sum;
            end
        end
    end

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

// File: rtl/sid_synth_top.sv
`timescale 1ns/1ps
`default_nettype none

module sid_synth_top #(
    parameter  int NUM_VOICES = 4,
    parameter  int SAMPLE_DIV = 256,
    // Headroom for up to four full-scale voices
    localparam int MIX_W      = synth_pkg::REG_W + 2
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             spi_clk,
    input  wire logic             spi_cs_n,
    input  wire logic             spi_mosi,
    output logic      [MIX_W-1:0] sample,
    output logic                  sample_valid
);

    import synth_pkg::*;

    // ======================================================================
    // Register bank to voices
    // ======================================================================

    logic [FREQ_W-1:0] freq    [NUM_VOICES];
    logic [REG_W-1:0]  pw      [NUM_VOICES];
    logic [REG_W-1:0]  attack  [NUM_VOICES];
    logic [REG_W-1:0]  sustain [NUM_VOICES];
    logic [REG_W-1:0]  wave    [NUM_VOICES];
    logic [REG_W-1:0]  level   [NUM_VOICES];
    logic              sample_tick;

    spi_voice_regs #(
        .NUM_VOICES (NUM_VOICES)
    ) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_clk  (spi_clk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .freq     (freq),
        .pw       (pw),
        .attack   (attack),
        .sustain  (sustain),
        .wave     (wave)
    );

    // One voice per register set
    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        sid_voice u_voice (
            .clk         (clk),
            .rst_n       (rst_n),
            .sample_tick (sample_tick),
            .freq        (freq[v]),
            .pw          (pw[v]),
            .attack      (attack[v]),
            .sustain     (sustain[v]),
            .wave        (wave[v]),
            .level       (level[v])
        );
    end

    // Tick source and output stage
    voice_mixer #(
        .NUM_VOICES (NUM_VOICES),
        .SAMPLE_DIV (SAMPLE_DIV),
        .MIX_W      (MIX_W)
    ) u_mixer (
        .clk          (clk),
        .rst_n        (rst_n),
        .level        (level),
        .sample_tick  (sample_tick),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

// File: verif/sid_model.svh
`ifndef SID_MODEL_SVH
`define SID_MODEL_SVH

// Envelope states as plain integers
localparam int ENV_IDLE    = 0;
localparam int ENV_ATTACK  = 1;
localparam int ENV_DECAY   = 2;
localparam int ENV_SUSTAIN = 3;
localparam int ENV_RELEASE = 4;

// Waveform value from the top phase byte, selected shapes ANDed
function automatic int wave_value(input int p, input int pw, input int wave);
    int shape;
    int picked;
    shape  = 255;
    picked = 0;
    if (((wave >> WAVE_SAW) & 1) != 0) begin
        shape  = shape & p;
        picked = 1;
    end
    if (((wave >> WAVE_TRI) & 1) != 0) begin
        // Ramp up over the first half, mirrored over the second
        shape  = shape & (((p << 1) & 255) ^ ((p >= 128) ? 255 : 0));
        picked = 1;
    end
    if (((wave >> WAVE_PULSE) & 1) != 0) begin
        shape  = shape & ((p < pw) ? 255 : 0);
        picked = 1;
    end
    return (picked != 0) ? shape : 0;
endfunction

// One envelope step, result packed as state * 256 + level
function automatic int env_next(input int state, input int env, input int gate,
                                input int ad, input int sr);
    int st;
    int e;
    int floor_lvl;
    st        = state;
    e         = env;
    floor_lvl = (sr & 15) * 17;
    if (gate != 0 && (st == ENV_IDLE || st == ENV_RELEASE)) begin
        st = ENV_ATTACK;
    end else if (gate == 0 && (st == ENV_ATTACK || st == ENV_DECAY || st == ENV_SUSTAIN)) begin
        st = ENV_RELEASE;
    end
    case (st)
        ENV_ATTACK: begin
            e = e + (ad & 15) + 1;
            if (e >= 255) begin
                e  = 255;
                st = ENV_DECAY;
            end
        end
        ENV_DECAY: begin
            e = e - ((ad >> 4) + 1);
            if (e <= floor_lvl) begin
                e  = floor_lvl;
                st = ENV_SUSTAIN;
            end
        end
        ENV_RELEASE: begin
            e = e - ((sr >> 4) + 1);
            if (e <= 0) begin
                e  = 0;
                st = ENV_IDLE;
            end
        end
        default: ;
    endcase
    return st * 256 + e;
endfunction

// Upper byte of wave times envelope
function automatic int voice_level(input int w, input int e);
    return (w * e) >> 8;
endfunction

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

`endif

// File: verif/sid_synth_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sid_synth_tb;

    import synth_pkg::*;

    // Three voices, so index 3 is out of range
    localparam int NUM_VOICES = 3;
    localparam int SAMPLE_DIV = 256;
    localparam int MIX_W      = REG_W + 2;
    localparam int CLK_NS     = 4;
    // Silence, ADSR, mix, ignored frames, restart
    localparam int TOTAL_SAMPLES = 8 + 117 + 58 + 14 + 29;
    localparam int WATCHDOG_NS   = TOTAL_SAMPLES * SAMPLE_DIV * CLK_NS * 2;

    logic             clk;
    logic             rst_n;
    logic             spi_clk;
    logic             spi_cs_n;
    logic             spi_mosi;
    logic [MIX_W-1:0] sample;
    logic             sample_valid;

    // Model copies of the voice registers
    int          reg_freq  [4];
    int          reg_pw    [4];
    int          reg_ad    [4];
    int          reg_sr    [4];
    int          reg_wave  [4];
    // Model voice state
    int          phase     [4];
    int          env_state [4];
    int          env_level [4];
    logic [31:0] rng;

    `include "sid_model.svh"

    sid_synth_top #(
        .NUM_VOICES (NUM_VOICES),
        .SAMPLE_DIV (SAMPLE_DIV)
    ) i_sid_synth_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .spi_clk      (spi_clk),
        .spi_cs_n     (spi_cs_n),
        .spi_mosi     (spi_mosi),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic check(input logic [31:0] got, input logic [31:0] expected,
                         input string what);
        if (got !== expected) begin
            $display("ERR at %0d ns: %s, got %0d, expected %0d", $time, what, got, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_valid();
        @(negedge clk);
        while (sample_valid !== 1'b1) @(negedge clk);
    endtask

    task automatic wait_samples(input int n);
        repeat (n) wait_valid();
    endtask

    // Mode 0, MSB first, SCLK period of 8 clocks
    task automatic send_frame(input logic [15:0] frame, input int nbits);
        wait_clks(1);
        spi_cs_n = 1'b0;
        wait_clks(4);
        for (int i = 0; i < nbits; i++) begin
            spi_mosi = frame[15 - i];
            wait_clks(4);
            spi_clk = 1'b1;
            wait_clks(4);
            spi_clk = 1'b0;
        end
        spi_mosi = 1'b0;
        wait_clks(4);
        spi_cs_n = 1'b1;
    endtask

    // One frame per sample period, right after a valid
    task automatic write_reg(input logic [2:0] addr, input logic [1:0] vidx,
                             input logic [7:0] data);
        int v;
        v = int'(vidx);
        wait_valid();
        send_frame({addr, vidx, 3'b000, data}, 16);
        if (v < NUM_VOICES) begin
            case (addr)
                REG_FREQ_LO: reg_freq[v] = (reg_freq[v] & 'hFF00) | int'(data);
                REG_FREQ_HI: reg_freq[v] = (reg_freq[v] & 'h00FF) | (int'(data) << 8);
                REG_PW:      reg_pw[v]   = int'(data);
                REG_AD:      reg_ad[v]   = int'(data);
                REG_SR:      reg_sr[v]   = int'(data);
                REG_WAVE:    reg_wave[v] = int'(data);
                default: ;
            endcase
        end
    endtask

    // Waveform register goes last so the gate opens on a complete setup
    task automatic setup_voice(input logic [1:0] v, input logic [15:0] freq,
                               input logic [7:0] pw, input logic [7:0] ad,
                               input logic [7:0] sr, input logic [7:0] wave);
        write_reg(REG_FREQ_LO, v, freq[7:0]);
        write_reg(REG_FREQ_HI, v, freq[15:8]);
        write_reg(REG_PW, v, pw);
        write_reg(REG_AD, v, ad);
        write_reg(REG_SR, v, sr);
        write_reg(REG_WAVE, v, wave);
    endtask

    // ======================================================================
    // Compare process and watchdog
    // ======================================================================

    initial begin : compare_samples
        int cycle;
        int last_valid;
        int total;
        int r;
        cycle      = 0;
        last_valid = -1;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            cycle++;
            if (sample_valid === 1'b1) begin
                if (last_valid >= 0) begin
                    check(cycle - last_valid, SAMPLE_DIV, "clocks between samples");
                end
                last_valid = cycle;
                // Step every voice once per tick
                total = 0;
                for (int v = 0; v < NUM_VOICES; v++) begin
                    phase[v]     = (phase[v] + reg_freq[v]) & 'hFFFFFF;
                    r            = env_next(env_state[v], env_level[v], reg_wave[v] & 1,
                                            reg_ad[v], reg_sr[v]);
                    env_state[v] = r >> 8;
                    env_level[v] = r & 255;
                    total        = total + voice_level(
                        wave_value(phase[v] >> 16, reg_pw[v], reg_wave[v]), env_level[v]);
                end
                check(32'(sample), total, "mixed sample");
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the test sequence did not finish within the watchdog limit");
        $display("Errors found");
        $fatal(1);
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin : run_tests
        rng      = 32'd55437;
        rst_n    = 1'b0;
        spi_clk  = 1'b0;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        for (int v = 0; v < 4; v++) begin
            reg_freq[v]  = 0;
            reg_pw[v]    = 0;
            reg_ad[v]    = 0;
            reg_sr[v]    = 0;
            reg_wave[v]  = 0;
            phase[v]     = 0;
            env_state[v] = ENV_IDLE;
            env_level[v] = 0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Nothing written, samples stay silent
        wait_samples(8);

        // Sawtooth, attack step 16, decay step 3 to 136, release step 4
        rng = xorshift(rng);
        setup_voice(2'd0, rng[15:0], 8'h00, 8'h2F, 8'h38, 8'h21);
        wait_samples(70);
        check(env_state[0], ENV_SUSTAIN, "voice 0 did not reach sustain");
        write_reg(REG_WAVE, 2'd0, 8'h20);
        wait_samples(40);
        check(env_state[0], ENV_IDLE, "voice 0 did not finish its release");

        // Triangle, pulse and pulse AND saw at full sustain
        rng = xorshift(rng);
        setup_voice(2'd0, rng[15:0], 8'h00, 8'h0F, 8'h0F, 8'h11);
        rng = xorshift(rng);
        setup_voice(2'd1, rng[15:0], rng[23:16], 8'h0F, 8'h0F, 8'h41);
        rng = xorshift(rng);
        setup_voice(2'd2, rng[15:0], rng[23:16], 8'h0F, 8'h0F, 8'h61);
        wait_samples(40);

        // Aborted frame would have silenced voice 0
        wait_valid();
        send_frame({REG_WAVE, 2'd0, 3'b000, 8'h00}, 9);
        write_reg(3'd3, 2'd0, 8'hFF);
        write_reg(3'd7, 2'd1, 8'h00);
        write_reg(REG_WAVE, 2'd3, 8'h00);
        wait_samples(10);

        // Gate drops, then returns mid release on voice 0
        write_reg(REG_SR, 2'd0, 8'h5F);
        write_reg(REG_WAVE, 2'd0, 8'h10);
        wait_samples(6);
        check(env_state[0], ENV_RELEASE, "voice 0 left release early");
        write_reg(REG_WAVE, 2'd0, 8'h11);
        wait_samples(20);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verif
rtl/synth_pkg.sv
rtl/spi_voice_regs.sv
rtl/sid_voice.sv
rtl/voice_mixer.sv
rtl/sid_synth_top.sv
verif/sid_synth_tb.sv

// File: Makefile
# Verilator build and run of the SID synthesizer testbench

VERILATOR ?= verilator
TOP       ?= sid_synth_tb
SEED_ARGS ?= +verilator+seed+55437
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) from sim.f with Verilator and run it"
	@echo "  clean  remove the build directory $(MDIR)"
	@echo "Variables: VERILATOR TOP SEED_ARGS MDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f sim.f
	./$(MDIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(MDIR)
